//--- common/bch_field_pkg.sv
package bch_field_pkg;

	// Binary BCH(15,7) over GF(2^4). The code corrects two errors per word.
	localparam int bch_m = 4;
	localparam int bch_n = (1 << bch_m) - 1;
	localparam int bch_k = 7;
	localparam int bch_ecc_bits = bch_n - bch_k;

	// Generator polynomial x^8+x^7+x^6+x^4+1.
	// Only the low coefficients are kept and the x^8 term is implied.
	localparam logic [bch_ecc_bits-1:0] bch_gen_poly = 8'hd1;

	// A lane moves one bit per cycle, so the cycle counts equal the bit counts.
	localparam int data_cycles = bch_k;
	localparam int ecc_cycles = bch_ecc_bits;

	// Message word as it arrives at the array.
	typedef logic [bch_k-1:0] msg_t;

	// Parity word, which is the remainder of the division.
	typedef logic [bch_ecc_bits-1:0] ecc_t;

	// Wide enough to count through one codeword.
	typedef logic [bch_m-1:0] cycle_count_t;

endpackage

//--- common/bch_array_pkg.sv
package bch_array_pkg;

	import bch_field_pkg::*;

	// Number of encoder lanes running side by side.
	localparam int lanes = 4;

	typedef logic [$clog2(lanes)-1:0] lane_id_t;

	// Serial input to one lane.
	// start marks the first data cycle, which carries the message MSB.
	typedef struct packed {
		logic start;
		logic data;
	} lane_in_t;

	// Serial output of one lane, one codeword bit per cycle.
	typedef struct packed {
		logic data;
		logic first;
		logic last;
		logic data_bits;
		logic ecc_bits;
	} lane_out_t;

	// Systematic layout: message bits go out first, then the parity.
	typedef struct packed {
		msg_t data;
		ecc_t ecc;
	} codeword_fields_t;

	// The first transmitted bit sits in the MSB of the raw view.
	typedef union packed {
		logic [bch_n-1:0] raw;
		codeword_fields_t fields;
	} codeword_u;

endpackage

//--- bch_encode/bch_encode.sv
`timescale 1ns/1ps

module bch_encode
	import bch_field_pkg::*;
	import bch_array_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  lane_in_t  lane_in,
	output lane_out_t lane_out,
	output logic      ready
);

	// Counter value in the final data cycle and in the cycle before the last one.
	// The counter reads 1 in the cycle after start and counts up while busy.

	logic         busy;
	logic         load_lfsr;
	logic         last;
	ecc_t         lfsr;
	ecc_t         lfsr_base;
	ecc_t         lfsr_div;
	logic         feedback;
	logic         data_bits;
	cycle_count_t count;

	// In the start cycle the division begins from an empty register.
	assign lfsr_base = lane_in.start ? '0 : lfsr;

	// One step of polynomial division by the generator.
	assign feedback = lane_in.data ^ lfsr_base[bch_ecc_bits-1];
	assign lfsr_div = {lfsr_base[bch_ecc_bits-2:0], 1'b0} ^ (feedback ? bch_gen_poly : '0);

	assign data_bits = lane_in.start || load_lfsr;

	// Data cycles pass the message through, parity cycles shift out the remainder MSB first.
	assign lane_out.data      = data_bits ? lane_in.data : lfsr[bch_ecc_bits-1];
	assign lane_out.first     = lane_in.start && !busy;
	assign lane_out.last      = last;
	assign lane_out.data_bits = data_bits;
	assign lane_out.ecc_bits  = busy && !data_bits;

	assign ready = !busy;

	// Control state of the lane.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			load_lfsr <= 1'b0;
			last      <= 1'b0;
			count     <= '0;
		end else begin
			if (lane_in.start) begin
				busy <= 1'b1;
				last <= 1'b0;
			end else if (count == cycle_count_t'(data_cycles + ecc_cycles - 2)) begin
				last <= busy;
			end else if (last) begin
				busy <= 1'b0;
				last <= 1'b0;
			end

			// Keep dividing until the last message bit has gone in.
			if (lane_in.start) begin
				load_lfsr <= 1'b1;
			end else if (count == cycle_count_t'(data_cycles - 1)) begin
				load_lfsr <= 1'b0;
			end

			if (lane_in.start) begin
				count <= cycle_count_t'(1);
			end else if (busy) begin
				count <= count + cycle_count_t'(1);
			end
		end
	end

	// The remainder register.
	always_ff @(posedge clk) begin
		if (data_bits) begin
			lfsr <= lfsr_div;
		end else if (busy) begin
			lfsr <= {lfsr[bch_ecc_bits-2:0], 1'b0};
		end
	end

	// A new word must wait until the previous one has fully left the lane.
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		lane_in.start |-> !busy);

	// The lane frees itself on the edge that ends the last cycle.
	a_last_then_ready: assert property (@(posedge clk) disable iff (!rst_n)
		lane_out.last |=> ready);

endmodule

//--- rtl/bch_msg_dispatch.sv
`timescale 1ns/1ps

module bch_msg_dispatch
	import bch_field_pkg::*;
	import bch_array_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   msg_valid,
	input  msg_t                   msg,
	output logic                   msg_ready,
	input  logic [lanes-1:0]       lane_ready,
	output lane_in_t [lanes-1:0]   lane_in
);

	lane_id_t         ptr;
	logic             accept;
	logic [lanes-1:0] start;
	msg_t             shreg [lanes];

	// Only the lane under the pointer may take the next message.
	assign msg_ready = lane_ready[ptr];
	assign accept    = msg_valid && msg_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr   <= '0;
			start <= '0;
		end else begin
			if (accept) begin
				ptr <= (ptr == lane_id_t'(lanes - 1)) ? '0 : ptr + lane_id_t'(1);
			end
			for (int i = 0; i < lanes; i++) begin
				start[i] <= accept && (ptr == lane_id_t'(i));
			end
		end
	end

	// Each lane has its own shift register, so several messages can be in flight.
	always_ff @(posedge clk) begin
		for (int i = 0; i < lanes; i++) begin
			if (accept && (ptr == lane_id_t'(i))) begin
				shreg[i] <= msg;
			end else begin
				shreg[i] <= {shreg[i][bch_k-2:0], 1'b0};
			end
		end
	end

	for (genvar i = 0; i < lanes; i++) begin : g_lane_in
		// The MSB leaves first, in the same cycle as start.
		assign lane_in[i].start = start[i];
		assign lane_in[i].data  = shreg[i][bch_k-1];

		// The lane must still be idle in the cycle where its start arrives.
		a_start_to_ready_lane: assert property (@(posedge clk) disable iff (!rst_n)
			lane_in[i].start |-> lane_ready[i]);
	end

endmodule

//--- rtl/bch_code_collect.sv
`timescale 1ns/1ps

module bch_code_collect
	import bch_field_pkg::*;
	import bch_array_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  lane_out_t [lanes-1:0] lane_out,
	output logic                  code_valid,
	output codeword_u             code,
	output lane_id_t              code_lane
);

	logic [bch_n-1:0] shreg [lanes];
	logic [bch_n-1:0] next_word [lanes];
	logic [lanes-1:0] last_vec;

	for (genvar i = 0; i < lanes; i++) begin : g_lane
		// A new codeword starts with its first bit, older contents drop out.
		assign next_word[i] = lane_out[i].first ?
			{{(bch_n - 1){1'b0}}, lane_out[i].data} :
			{shreg[i][bch_n-2:0], lane_out[i].data};

		assign last_vec[i] = lane_out[i].last;

		always_ff @(posedge clk) begin
			if (lane_out[i].data_bits || lane_out[i].ecc_bits) begin
				shreg[i] <= next_word[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= |last_vec;
		end
	end

	// The word is taken together with its final bit, so no extra cycle is spent.
	always_ff @(posedge clk) begin
		for (int i = 0; i < lanes; i++) begin
			if (last_vec[i]) begin
				code.raw  <= next_word[i];
				code_lane <= lane_id_t'(i);
			end
		end
	end

	// Round robin launch keeps the lanes at least one cycle apart.
	a_one_last: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(last_vec));

endmodule

//--- rtl/bch_encode_array.sv
`timescale 1ns/1ps

module bch_encode_array
	import bch_field_pkg::*;
	import bch_array_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      msg_valid,
	input  msg_t      msg,
	output logic      msg_ready,
	output logic      code_valid,
	output codeword_u code,
	output lane_id_t  code_lane
);

	lane_in_t  [lanes-1:0] lane_in;
	lane_out_t [lanes-1:0] lane_out;
	logic      [lanes-1:0] lane_ready;

	bch_msg_dispatch u_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.msg_valid  (msg_valid),
		.msg        (msg),
		.msg_ready  (msg_ready),
		.lane_ready (lane_ready),
		.lane_in    (lane_in)
	);

	// One serial encoder per lane.
	for (genvar i = 0; i < lanes; i++) begin : g_lane
		bch_encode u_encode (
			.clk      (clk),
			.rst_n    (rst_n),
			.lane_in  (lane_in[i]),
			.lane_out (lane_out[i]),
			.ready    (lane_ready[i])
		);
	end

	bch_code_collect u_collect (
		.clk        (clk),
		.rst_n      (rst_n),
		.lane_out   (lane_out),
		.code_valid (code_valid),
		.code       (code),
		.code_lane  (code_lane)
	);

endmodule

//--- dv/bch_encode_array_tb.sv
`timescale 1ns/1ps

module bch_encode_array_tb
	import bch_field_pkg::*;
	import bch_array_pkg::*;
();

	// Generator x^8+x^7+x^6+x^4+1 with its leading term.
	localparam logic [bch_ecc_bits:0] gen_full = 9'h1d1;

	// Start comes one cycle after the accept, then fifteen serial bits,
	// and the collector registers the word on the edge that ends the last one.
	localparam int latency_cycles = 1 + bch_n;

	// A lane is busy from the edge after its start until the edge that ends
	// its fifteenth cycle, so it takes a new message every n+1 cycles.
	localparam int lane_period = bch_n + 1;

	localparam int quiet_cycles = 20;
	localparam int ready_timeout = 64;
	localparam int drain_timeout = 128;
	localparam int random_count = 300;
	localparam int max_gap = 6;
	localparam int sat_cycles = 2 * lane_period + lanes;

	typedef struct packed {
		msg_t        data;
		ecc_t        ecc;
		lane_id_t    lane;
		logic [31:0] cycle;
	} expect_t;

	logic      clk;
	logic      rst_n;
	logic      msg_valid;
	msg_t      msg;
	logic      msg_ready;
	logic      code_valid;
	codeword_u code;
	lane_id_t  code_lane;

	expect_t     exp_q [$];
	expect_t     head;
	logic        head_valid;
	int          accept_count;
	logic [31:0] cycle_no;
	logic        reset_window;

	string test_name;
	int    error_count;
	int    test_errors;
	int    tests_run;
	int    codes_checked;

	bch_encode_array DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.msg_valid  (msg_valid),
		.msg        (msg),
		.msg_ready  (msg_ready),
		.code_valid (code_valid),
		.code       (code),
		.code_lane  (code_lane)
	);

	always #20 clk = ~clk;

	// Remainder of a codeword polynomial after division by the generator.
	function automatic ecc_t poly_remainder(input logic [bch_n-1:0] word);
		logic [bch_n-1:0] r;
		logic [bch_n-1:0] gen_word;
		r = word;
		gen_word = bch_n'(gen_full);
		for (int i = bch_n - 1; i >= bch_ecc_bits; i--) begin
			if (r[i]) begin
				r = r ^ (gen_word << (i - bch_ecc_bits));
			end
		end
		return r[bch_ecc_bits-1:0];
	endfunction

	task automatic note_mismatch(input string what, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("error: %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
		error_count++;
	endtask

	task automatic flag_failure(input string what);
		$display("%s: %s", test_name, what);
		error_count++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = error_count;
		tests_run++;
	endtask

	task automatic end_test();
		$display("test %s done with %0d errors", test_name, error_count - test_errors);
	endtask

	// Called just after a falling edge. Waits for the pointed lane, then strobes one message.
	task automatic send_message(input msg_t value);
		int waited;
		waited = 0;
		while (!msg_ready && waited < ready_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (msg_ready) begin
			msg_valid = 1'b1;
			msg = value;
			@(negedge clk);
			msg_valid = 1'b0;
		end else begin
			flag_failure("msg_ready stayed low while a message was waiting");
		end
	endtask

	task automatic drain_codewords();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < drain_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			flag_failure("codewords were still outstanding when the drain timed out");
		end
	endtask

	always @(posedge clk) begin
		cycle_no <= cycle_no + 32'd1;
	end

	// Reference model and scoreboard. Head values move by NBA, like the DUT outputs.
	always @(posedge clk) begin
		expect_t entry;
		if (!rst_n) begin
			exp_q.delete();
			accept_count = 0;
		end else begin
			// A valid codeword, read as a polynomial, is a multiple of the generator.
			if (code_valid) begin
				assert (poly_remainder(code.raw) == '0)
					else note_mismatch("codeword remainder", 32'(0),
						32'(poly_remainder(code.raw)));
			end
			if (code_valid && exp_q.size() > 0) begin
				void'(exp_q.pop_front());
				codes_checked++;
			end
			if (msg_valid && msg_ready) begin
				entry.data = msg;
				entry.ecc = poly_remainder({msg, ecc_t'(0)});
				// Lanes take messages in turn, beginning with lane 0 after reset.
				entry.lane = lane_id_t'(accept_count % lanes);
				entry.cycle = cycle_no;
				exp_q.push_back(entry);
				accept_count++;
			end
		end
		head_valid <= (exp_q.size() > 0);
		if (exp_q.size() > 0) begin
			head <= exp_q[0];
		end
	end

	a_reset_ready: assert property (@(posedge clk) disable iff (!rst_n)
		reset_window |-> msg_ready)
		else flag_failure("msg_ready was low right after reset");

	a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		reset_window |-> !code_valid)
		else flag_failure("code_valid rose right after reset");

	a_code_expected: assert property (@(posedge clk) disable iff (!rst_n)
		code_valid |-> head_valid)
		else flag_failure("a codeword came out with no message outstanding");

	a_code_raw: assert property (@(posedge clk) disable iff (!rst_n)
		code_valid && head_valid |-> code.raw == {head.data, head.ecc})
		else note_mismatch("raw codeword", 32'($sampled({head.data, head.ecc})),
			32'($sampled(code.raw)));

	a_code_data: assert property (@(posedge clk) disable iff (!rst_n)
		code_valid && head_valid |-> code.fields.data == head.data)
		else note_mismatch("data field", 32'($sampled(head.data)),
			32'($sampled(code.fields.data)));

	a_code_ecc: assert property (@(posedge clk) disable iff (!rst_n)
		code_valid && head_valid |-> code.fields.ecc == head.ecc)
		else note_mismatch("ecc field", 32'($sampled(head.ecc)),
			32'($sampled(code.fields.ecc)));

	a_code_lane: assert property (@(posedge clk) disable iff (!rst_n)
		code_valid && head_valid |-> code_lane == head.lane)
		else note_mismatch("code_lane", 32'($sampled(head.lane)), 32'($sampled(code_lane)));

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		code_valid && head_valid |-> (cycle_no - head.cycle) == latency_cycles)
		else note_mismatch("latency", 32'(latency_cycles),
			$sampled(cycle_no) - $sampled(head.cycle));

	// Backstop in case a wait loop itself misbehaves.
	initial begin
		#1_000_000;
		$display("simulation time limit reached before the tests finished");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int   gap;
		logic ready_exp;
		void'($urandom(32'h989180b0));
		clk = 1'b0;
		rst_n = 1'b0;
		msg_valid = 1'b0;
		msg = '0;
		cycle_no = '0;
		reset_window = 1'b0;
		error_count = 0;
		tests_run = 0;
		codes_checked = 0;
		test_name = "setup";
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		begin_test("reset_state");
		reset_window = 1'b1;
		repeat (quiet_cycles) @(negedge clk);
		reset_window = 1'b0;
		end_test();

		begin_test("single_messages");
		send_message(7'h00);
		drain_codewords();
		send_message(7'h7f);
		drain_codewords();
		send_message(7'h01);
		drain_codewords();
		end_test();

		// With every lane idle, the first lane_period cycles accept exactly one round.
		begin_test("saturation");
		for (int c = 0; c < sat_cycles; c++) begin
			msg_valid = 1'b1;
			msg = msg_t'($urandom);
			ready_exp = (c % lane_period) < lanes;
			assert (msg_ready == ready_exp)
				else note_mismatch($sformatf("msg_ready in cycle %0d", c),
					32'(ready_exp), 32'(msg_ready));
			@(negedge clk);
		end
		msg_valid = 1'b0;
		drain_codewords();
		end_test();

		begin_test("ordering");
		for (int i = 0; i < 2 * lanes + 2; i++) begin
			send_message(msg_t'($urandom));
		end
		drain_codewords();
		end_test();

		begin_test("random_traffic");
		for (int i = 0; i < random_count; i++) begin
			gap = int'($urandom_range(max_gap, 0));
			repeat (gap) @(negedge clk);
			send_message(msg_t'($urandom));
		end
		drain_codewords();
		assert (exp_q.size() == 0)
			else flag_failure("the expected queue was not empty at the end");
		end_test();

		$display("summary: %0d tests, %0d codewords checked, %0d errors",
			tests_run, codes_checked, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- bch_encode_array.f
common/bch_field_pkg.sv
common/bch_array_pkg.sv
bch_encode/bch_encode.sv
rtl/bch_msg_dispatch.sv
rtl/bch_code_collect.sv
rtl/bch_encode_array.sv
dv/bch_encode_array_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = bch_encode_array_tb
FILELIST = bch_encode_array.f
LOG      = sim.log
FAIL_MSG = Testbench failed

.PHONY: sim clean

# The run fails if the simulator exits with an error or the log holds the fail message.
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
